// File: common/cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  // Kept subset of the 6502 opcode map
  typedef enum logic [DATA_W-1:0] {
    OP_NOP     = 8'hEA,
    OP_SEC     = 8'h38,
    OP_CLC     = 8'h18,
    OP_LDA_IMM = 8'hA9,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_IMM = 8'hA0,
    OP_LDA_ZP  = 8'hA5,
    OP_LDX_ZP  = 8'hA6,
    OP_LDY_ZP  = 8'hA4,
    OP_STA_ZP  = 8'h85,
    OP_ADC_IMM = 8'h69,
    OP_SBC_IMM = 8'hE9,
    OP_TAX     = 8'hAA,
    OP_TAY     = 8'hA8,
    OP_TXA     = 8'h8A,
    OP_TYA     = 8'h98,
    OP_TXS     = 8'h9A,
    OP_TSX     = 8'hBA,
    OP_LDA_ABS = 8'hAD,
    OP_JMP_ABS = 8'h4C
  } opcode_e;

  // Bit positions in the status register
  localparam int STATUS_CARRY    = 0;
  localparam int STATUS_ZERO     = 1;
  localparam int STATUS_OVERFLOW = 6;
  localparam int STATUS_NEGATIVE = 7;

  // Low byte of the start vector, high byte follows
  localparam logic [ADDR_W-1:0] RESET_VECTOR_ADDR = 16'hFFFC;

  localparam logic [DATA_W-1:0] STATUS_RESET = 8'b00110100;

endpackage

// File: common/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  typedef enum logic [2:0] {
    FETCH,
    OPERAND,
    MEMORY,
    FINAL,
    VECTOR_LOW,
    VECTOR_HIGH
  } stage_e;

  typedef enum logic {
    ALU_ADC,
    ALU_SBC
  } alu_op_e;

  typedef enum logic [1:0] {
    REG_A,
    REG_X,
    REG_Y,
    REG_SP
  } reg_sel_e;

  // Value source of a register write
  typedef enum logic [1:0] {
    SRC_BUS,
    SRC_REG,
    SRC_ALU
  } src_sel_e;

  // Source of the next bus address, KEEP holds it during a stall
  typedef enum logic [2:0] {
    ADDR_KEEP,
    ADDR_PC_NEXT,
    ADDR_ZERO_PAGE,
    ADDR_HOLD,
    ADDR_VECTOR_HIGH
  } addr_sel_e;

endpackage

// File: logic/alu.sv
`timescale 1ns/10ps

module alu (
  input  cpu_ctrl_pkg::alu_op_e          alu_op_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] a_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] b_i,
  input  logic                           carry_i,
  output logic [cpu_isa_pkg::DATA_W-1:0] result_o,
  output logic [2:0]                     flags_o
);

  logic [cpu_isa_pkg::DATA_W-1:0] operand;
  logic [cpu_isa_pkg::DATA_W:0]   sum;

  // Subtract is add of the inverted operand, carry acts as not-borrow
  assign operand = (alu_op_i == cpu_ctrl_pkg::ALU_SBC) ? ~b_i : b_i;

  assign sum = {1'b0, a_i} + {1'b0, operand} + {{cpu_isa_pkg::DATA_W{1'b0}}, carry_i};

  assign result_o = sum[cpu_isa_pkg::DATA_W-1:0];

  // N, Z, C from msb to lsb
  assign flags_o = {sum[cpu_isa_pkg::DATA_W-1],
                    (sum[cpu_isa_pkg::DATA_W-1:0] == '0),
                    sum[cpu_isa_pkg::DATA_W]};

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic                           clock_i,
  input  logic                           reset_i,
  input  logic                           reg_we_i,
  input  cpu_ctrl_pkg::reg_sel_e         reg_dst_i,
  input  cpu_ctrl_pkg::src_sel_e         reg_src_i,
  input  cpu_ctrl_pkg::reg_sel_e         reg_copy_src_i,
  input  logic                           flag_load_nz_i,
  input  logic                           carry_we_i,
  input  logic                           carry_value_i,
  input  logic                           alu_flags_we_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] data_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] alu_result_i,
  input  logic [2:0]                     alu_flags_i,
  output logic [cpu_isa_pkg::DATA_W-1:0] accumulator_o,
  output logic                           carry_o
);

  logic [cpu_isa_pkg::DATA_W-1:0] accumulator;
  logic [cpu_isa_pkg::DATA_W-1:0] index_x;
  logic [cpu_isa_pkg::DATA_W-1:0] index_y;
  logic [cpu_isa_pkg::DATA_W-1:0] stack_pointer;
  logic [cpu_isa_pkg::DATA_W-1:0] status;
  logic [cpu_isa_pkg::DATA_W-1:0] copy_value;
  logic [cpu_isa_pkg::DATA_W-1:0] write_value;

  always_comb begin
    case (reg_copy_src_i)
      cpu_ctrl_pkg::REG_A: copy_value = accumulator;
      cpu_ctrl_pkg::REG_X: copy_value = index_x;
      cpu_ctrl_pkg::REG_Y: copy_value = index_y;
      default:             copy_value = stack_pointer;
    endcase
    case (reg_src_i)
      cpu_ctrl_pkg::SRC_REG: write_value = copy_value;
      cpu_ctrl_pkg::SRC_ALU: write_value = alu_result_i;
      default:               write_value = data_i;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      accumulator   <= '0;
      index_x       <= '0;
      index_y       <= '0;
      stack_pointer <= '0;
      status        <= cpu_isa_pkg::STATUS_RESET;
    end else begin
      if (reg_we_i) begin
        case (reg_dst_i)
          cpu_ctrl_pkg::REG_A: accumulator <= write_value;
          cpu_ctrl_pkg::REG_X: index_x <= write_value;
          cpu_ctrl_pkg::REG_Y: index_y <= write_value;
          default:             stack_pointer <= write_value;
        endcase
      end
      if (flag_load_nz_i) begin
        status[cpu_isa_pkg::STATUS_ZERO]     <= (write_value == '0);
        status[cpu_isa_pkg::STATUS_NEGATIVE] <= write_value[cpu_isa_pkg::DATA_W-1];
      end
      if (carry_we_i) begin
        status[cpu_isa_pkg::STATUS_CARRY] <= carry_value_i;
      end
      if (alu_flags_we_i) begin
        status[cpu_isa_pkg::STATUS_CARRY]    <= alu_flags_i[0];
        status[cpu_isa_pkg::STATUS_ZERO]     <= alu_flags_i[1];
        status[cpu_isa_pkg::STATUS_NEGATIVE] <= alu_flags_i[2];
        // No overflow detection
        status[cpu_isa_pkg::STATUS_OVERFLOW] <= 1'b0;
      end
    end
  end

  assign accumulator_o = accumulator;
  assign carry_o       = status[cpu_isa_pkg::STATUS_CARRY];

endmodule

// File: logic/address_unit.sv
`timescale 1ns/10ps

module address_unit (
  input  logic                           clock_i,
  input  logic                           reset_i,
  input  logic                           pc_inc_i,
  input  logic                           pc_load_low_i,
  input  logic                           pc_load_high_i,
  input  cpu_ctrl_pkg::addr_sel_e        addr_sel_i,
  input  logic                           hold_we_i,
  input  logic                           bus_read_i,
  input  logic                           bus_write_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] data_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] accumulator_i,
  output logic [cpu_isa_pkg::ADDR_W-1:0] address_o,
  output logic [cpu_isa_pkg::DATA_W-1:0] data_o,
  output logic                           bus_read_o,
  output logic                           bus_write_o
);

  localparam int PAGE_W = cpu_isa_pkg::ADDR_W - cpu_isa_pkg::DATA_W;

  logic [cpu_isa_pkg::ADDR_W-1:0] pc;
  logic [cpu_isa_pkg::ADDR_W-1:0] pc_next;
  logic [cpu_isa_pkg::DATA_W-1:0] hold;
  logic [cpu_isa_pkg::ADDR_W-1:0] next_address;

  assign pc_next = pc + cpu_isa_pkg::ADDR_W'(1);

  always_comb begin
    case (addr_sel_i)
      cpu_ctrl_pkg::ADDR_PC_NEXT:     next_address = pc_next;
      cpu_ctrl_pkg::ADDR_ZERO_PAGE:   next_address = {{PAGE_W{1'b0}}, data_i};
      // High byte arrives on the bus, low byte was held
      cpu_ctrl_pkg::ADDR_HOLD:        next_address = {data_i, hold};
      cpu_ctrl_pkg::ADDR_VECTOR_HIGH:
        next_address = cpu_isa_pkg::RESET_VECTOR_ADDR + cpu_isa_pkg::ADDR_W'(1);
      default:                        next_address = address_o;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pc          <= cpu_isa_pkg::RESET_VECTOR_ADDR;
      address_o   <= cpu_isa_pkg::RESET_VECTOR_ADDR;
      bus_read_o  <= 1'b1;
      bus_write_o <= 1'b0;
    end else begin
      address_o   <= next_address;
      bus_read_o  <= bus_read_i;
      bus_write_o <= bus_write_i;
      if (pc_inc_i) begin
        pc <= pc_next;
      end else begin
        if (pc_load_low_i) begin
          pc[cpu_isa_pkg::DATA_W-1:0] <= data_i;
        end
        if (pc_load_high_i) begin
          pc[cpu_isa_pkg::ADDR_W-1:cpu_isa_pkg::DATA_W] <= data_i;
        end
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (hold_we_i) begin
      hold <= data_i;
    end
    if (bus_write_i) begin
      data_o <= accumulator_i;
    end
  end

endmodule

// File: sequencer/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer (
  input  logic                           clock_i,
  input  logic                           reset_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] data_i,
  input  logic                           data_valid_i,
  output logic                           reg_we_o,
  output cpu_ctrl_pkg::reg_sel_e         reg_dst_o,
  output cpu_ctrl_pkg::src_sel_e         reg_src_o,
  output cpu_ctrl_pkg::reg_sel_e         reg_copy_src_o,
  output logic                           flag_load_nz_o,
  output logic                           carry_we_o,
  output logic                           carry_value_o,
  output logic                           alu_flags_we_o,
  output cpu_ctrl_pkg::alu_op_e          alu_op_o,
  output logic                           pc_inc_o,
  output logic                           pc_load_low_o,
  output logic                           pc_load_high_o,
  output cpu_ctrl_pkg::addr_sel_e        addr_sel_o,
  output logic                           hold_we_o,
  output logic                           bus_read_o,
  output logic                           bus_write_o
);

  cpu_ctrl_pkg::stage_e stage;
  cpu_ctrl_pkg::stage_e next_stage;
  cpu_isa_pkg::opcode_e opcode;
  logic                 opcode_we;
  logic                 needs_byte;
  logic                 step_pc;
  logic                 finish;

  // Opcodes followed by at least one operand byte
  function automatic logic has_operand(cpu_isa_pkg::opcode_e op);
    case (op)
      cpu_isa_pkg::OP_LDA_IMM, cpu_isa_pkg::OP_LDX_IMM, cpu_isa_pkg::OP_LDY_IMM,
      cpu_isa_pkg::OP_LDA_ZP, cpu_isa_pkg::OP_LDX_ZP, cpu_isa_pkg::OP_LDY_ZP,
      cpu_isa_pkg::OP_STA_ZP, cpu_isa_pkg::OP_ADC_IMM, cpu_isa_pkg::OP_SBC_IMM,
      cpu_isa_pkg::OP_LDA_ABS, cpu_isa_pkg::OP_JMP_ABS: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic cpu_ctrl_pkg::reg_sel_e load_dst(cpu_isa_pkg::opcode_e op);
    case (op)
      cpu_isa_pkg::OP_LDX_IMM, cpu_isa_pkg::OP_LDX_ZP: return cpu_ctrl_pkg::REG_X;
      cpu_isa_pkg::OP_LDY_IMM, cpu_isa_pkg::OP_LDY_ZP: return cpu_ctrl_pkg::REG_Y;
      default: return cpu_ctrl_pkg::REG_A;
    endcase
  endfunction

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage  <= cpu_ctrl_pkg::VECTOR_LOW;
      opcode <= cpu_isa_pkg::OP_NOP;
    end else begin
      stage <= next_stage;
      if (opcode_we) begin
        opcode <= cpu_isa_pkg::opcode_e'(data_i);
      end
    end
  end

  // Implied operations and the STA tail run without a byte
  always_comb begin
    case (stage)
      cpu_ctrl_pkg::OPERAND: needs_byte = has_operand(opcode);
      cpu_ctrl_pkg::MEMORY:  needs_byte = (opcode != cpu_isa_pkg::OP_STA_ZP);
      default:               needs_byte = 1'b1;
    endcase
  end

  assign alu_op_o = (opcode == cpu_isa_pkg::OP_SBC_IMM) ? cpu_ctrl_pkg::ALU_SBC
                                                        : cpu_ctrl_pkg::ALU_ADC;

  always_comb begin
    next_stage     = stage;
    opcode_we      = 1'b0;
    step_pc        = 1'b0;
    finish         = 1'b0;
    reg_we_o       = 1'b0;
    reg_dst_o      = cpu_ctrl_pkg::REG_A;
    reg_src_o      = cpu_ctrl_pkg::SRC_BUS;
    reg_copy_src_o = cpu_ctrl_pkg::REG_A;
    flag_load_nz_o = 1'b0;
    carry_we_o     = 1'b0;
    carry_value_o  = 1'b0;
    alu_flags_we_o = 1'b0;
    pc_inc_o       = 1'b0;
    pc_load_low_o  = 1'b0;
    pc_load_high_o = 1'b0;
    addr_sel_o     = cpu_ctrl_pkg::ADDR_KEEP;
    hold_we_o      = 1'b0;
    bus_read_o     = 1'b0;
    bus_write_o    = 1'b0;

    if (needs_byte && !data_valid_i) begin
      // Stall with the read request and address held
      bus_read_o = 1'b1;
    end else begin
      case (stage)
        cpu_ctrl_pkg::FETCH: begin
          opcode_we  = 1'b1;
          next_stage = cpu_ctrl_pkg::OPERAND;
          step_pc    = has_operand(cpu_isa_pkg::opcode_e'(data_i));
        end
        cpu_ctrl_pkg::OPERAND: begin
          case (opcode)
            cpu_isa_pkg::OP_LDA_IMM, cpu_isa_pkg::OP_LDX_IMM, cpu_isa_pkg::OP_LDY_IMM: begin
              reg_we_o       = 1'b1;
              reg_dst_o      = load_dst(opcode);
              flag_load_nz_o = 1'b1;
              finish         = 1'b1;
            end
            cpu_isa_pkg::OP_ADC_IMM, cpu_isa_pkg::OP_SBC_IMM: begin
              reg_we_o       = 1'b1;
              reg_src_o      = cpu_ctrl_pkg::SRC_ALU;
              alu_flags_we_o = 1'b1;
              finish         = 1'b1;
            end
            cpu_isa_pkg::OP_LDA_ZP, cpu_isa_pkg::OP_LDX_ZP, cpu_isa_pkg::OP_LDY_ZP: begin
              addr_sel_o = cpu_ctrl_pkg::ADDR_ZERO_PAGE;
              bus_read_o = 1'b1;
              next_stage = cpu_ctrl_pkg::MEMORY;
            end
            cpu_isa_pkg::OP_STA_ZP: begin
              addr_sel_o  = cpu_ctrl_pkg::ADDR_ZERO_PAGE;
              bus_write_o = 1'b1;
              next_stage  = cpu_ctrl_pkg::MEMORY;
            end
            cpu_isa_pkg::OP_LDA_ABS, cpu_isa_pkg::OP_JMP_ABS: begin
              // Low address byte into hold, read the high byte
              hold_we_o     = 1'b1;
              pc_load_low_o = (opcode == cpu_isa_pkg::OP_JMP_ABS);
              addr_sel_o    = cpu_ctrl_pkg::ADDR_PC_NEXT;
              bus_read_o    = 1'b1;
              next_stage    = cpu_ctrl_pkg::MEMORY;
            end
            cpu_isa_pkg::OP_SEC, cpu_isa_pkg::OP_CLC: begin
              carry_we_o    = 1'b1;
              carry_value_o = (opcode == cpu_isa_pkg::OP_SEC);
              finish        = 1'b1;
            end
            cpu_isa_pkg::OP_TAX, cpu_isa_pkg::OP_TAY, cpu_isa_pkg::OP_TXA,
            cpu_isa_pkg::OP_TYA, cpu_isa_pkg::OP_TXS, cpu_isa_pkg::OP_TSX: begin
              reg_we_o       = 1'b1;
              reg_src_o      = cpu_ctrl_pkg::SRC_REG;
              flag_load_nz_o = (opcode != cpu_isa_pkg::OP_TXS);
              finish         = 1'b1;
              case (opcode)
                cpu_isa_pkg::OP_TAX: reg_dst_o = cpu_ctrl_pkg::REG_X;
                cpu_isa_pkg::OP_TAY: reg_dst_o = cpu_ctrl_pkg::REG_Y;
                cpu_isa_pkg::OP_TXA: reg_copy_src_o = cpu_ctrl_pkg::REG_X;
                cpu_isa_pkg::OP_TYA: reg_copy_src_o = cpu_ctrl_pkg::REG_Y;
                cpu_isa_pkg::OP_TXS: begin
                  reg_dst_o      = cpu_ctrl_pkg::REG_SP;
                  reg_copy_src_o = cpu_ctrl_pkg::REG_X;
                end
                default: begin
                  reg_dst_o      = cpu_ctrl_pkg::REG_X;
                  reg_copy_src_o = cpu_ctrl_pkg::REG_SP;
                end
              endcase
            end
            // NOP and unknown codes
            default: finish = 1'b1;
          endcase
        end
        cpu_ctrl_pkg::MEMORY: begin
          case (opcode)
            cpu_isa_pkg::OP_LDA_ZP, cpu_isa_pkg::OP_LDX_ZP, cpu_isa_pkg::OP_LDY_ZP: begin
              reg_we_o       = 1'b1;
              reg_dst_o      = load_dst(opcode);
              flag_load_nz_o = 1'b1;
              finish         = 1'b1;
            end
            cpu_isa_pkg::OP_LDA_ABS: begin
              pc_inc_o   = 1'b1;
              addr_sel_o = cpu_ctrl_pkg::ADDR_HOLD;
              bus_read_o = 1'b1;
              next_stage = cpu_ctrl_pkg::FINAL;
            end
            cpu_isa_pkg::OP_JMP_ABS: begin
              pc_load_high_o = 1'b1;
              addr_sel_o     = cpu_ctrl_pkg::ADDR_HOLD;
              bus_read_o     = 1'b1;
              next_stage     = cpu_ctrl_pkg::FETCH;
            end
            default: finish = 1'b1;
          endcase
        end
        cpu_ctrl_pkg::FINAL: begin
          reg_we_o       = 1'b1;
          flag_load_nz_o = 1'b1;
          finish         = 1'b1;
        end
        cpu_ctrl_pkg::VECTOR_LOW: begin
          hold_we_o     = 1'b1;
          pc_load_low_o = 1'b1;
          addr_sel_o    = cpu_ctrl_pkg::ADDR_VECTOR_HIGH;
          bus_read_o    = 1'b1;
          next_stage    = cpu_ctrl_pkg::VECTOR_HIGH;
        end
        cpu_ctrl_pkg::VECTOR_HIGH: begin
          pc_load_high_o = 1'b1;
          addr_sel_o     = cpu_ctrl_pkg::ADDR_HOLD;
          bus_read_o     = 1'b1;
          next_stage     = cpu_ctrl_pkg::FETCH;
        end
        default: finish = 1'b1;
      endcase
    end

    // Common tail: step to the next program byte and read it
    if (finish) begin
      step_pc    = 1'b1;
      next_stage = cpu_ctrl_pkg::FETCH;
    end
    if (step_pc) begin
      pc_inc_o   = 1'b1;
      addr_sel_o = cpu_ctrl_pkg::ADDR_PC_NEXT;
      bus_read_o = 1'b1;
    end
  end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic                           clock_i,
  input  logic                           reset_i,
  input  logic [cpu_isa_pkg::DATA_W-1:0] data_i,
  input  logic                           data_valid_i,
  output logic [cpu_isa_pkg::ADDR_W-1:0] address_o,
  output logic [cpu_isa_pkg::DATA_W-1:0] data_o,
  output logic                           bus_read_o,
  output logic                           bus_write_o
);

  logic                           reg_we;
  cpu_ctrl_pkg::reg_sel_e         reg_dst;
  cpu_ctrl_pkg::src_sel_e         reg_src;
  cpu_ctrl_pkg::reg_sel_e         reg_copy_src;
  logic                           flag_load_nz;
  logic                           carry_we;
  logic                           carry_value;
  logic                           alu_flags_we;
  cpu_ctrl_pkg::alu_op_e          alu_op;
  logic                           pc_inc;
  logic                           pc_load_low;
  logic                           pc_load_high;
  cpu_ctrl_pkg::addr_sel_e        addr_sel;
  logic                           hold_we;
  logic                           bus_read;
  logic                           bus_write;
  logic [cpu_isa_pkg::DATA_W-1:0] accumulator;
  logic                           carry;
  logic [cpu_isa_pkg::DATA_W-1:0] alu_result;
  logic [2:0]                     alu_flags;

  cpu_sequencer sequencer0 (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .data_i         (data_i),
    .data_valid_i   (data_valid_i),
    .reg_we_o       (reg_we),
    .reg_dst_o      (reg_dst),
    .reg_src_o      (reg_src),
    .reg_copy_src_o (reg_copy_src),
    .flag_load_nz_o (flag_load_nz),
    .carry_we_o     (carry_we),
    .carry_value_o  (carry_value),
    .alu_flags_we_o (alu_flags_we),
    .alu_op_o       (alu_op),
    .pc_inc_o       (pc_inc),
    .pc_load_low_o  (pc_load_low),
    .pc_load_high_o (pc_load_high),
    .addr_sel_o     (addr_sel),
    .hold_we_o      (hold_we),
    .bus_read_o     (bus_read),
    .bus_write_o    (bus_write)
  );

  alu alu0 (
    .alu_op_i (alu_op),
    .a_i      (accumulator),
    .b_i      (data_i),
    .carry_i  (carry),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  register_file register_file0 (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .reg_we_i       (reg_we),
    .reg_dst_i      (reg_dst),
    .reg_src_i      (reg_src),
    .reg_copy_src_i (reg_copy_src),
    .flag_load_nz_i (flag_load_nz),
    .carry_we_i     (carry_we),
    .carry_value_i  (carry_value),
    .alu_flags_we_i (alu_flags_we),
    .data_i         (data_i),
    .alu_result_i   (alu_result),
    .alu_flags_i    (alu_flags),
    .accumulator_o  (accumulator),
    .carry_o        (carry)
  );

  address_unit address_unit0 (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .pc_inc_i       (pc_inc),
    .pc_load_low_i  (pc_load_low),
    .pc_load_high_i (pc_load_high),
    .addr_sel_i     (addr_sel),
    .hold_we_i      (hold_we),
    .bus_read_i     (bus_read),
    .bus_write_i    (bus_write),
    .data_i         (data_i),
    .accumulator_i  (accumulator),
    .address_o      (address_o),
    .data_o         (data_o),
    .bus_read_o     (bus_read_o),
    .bus_write_o    (bus_write_o)
  );

endmodule

// File: dv/cpu_chk.sv
`timescale 1ns/10ps

module cpu_chk (
  input logic        clock_i,
  input logic        reset_i,
  input logic        data_valid_i,
  input logic [15:0] address_i,
  input logic        bus_read_i,
  input logic        bus_write_i
);

  read_write_exclusive: assert property (
    @(posedge clock_i) disable iff (reset_i) !(bus_read_i && bus_write_i)
  ) else $error("bus_read_o and bus_write_o are high in the same cycle");

  // First request out of reset is the low vector byte
  first_read_at_vector: assert property (
    @(posedge clock_i) $fell(reset_i) |-> (bus_read_i && address_i == 16'hFFFC)
  ) else $error("First read after reset is not at the start vector");

  stall_address_stable: assert property (
    @(posedge clock_i) disable iff (reset_i)
      (bus_read_i && !data_valid_i) |=> $stable(address_i)
  ) else $error("address_o changed while a read was still waiting");

endmodule

bind cpu_top cpu_chk cpu_chk0 (
  .clock_i      (clock_i),
  .reset_i      (reset_i),
  .data_valid_i (data_valid_i),
  .address_i    (address_o),
  .bus_read_i   (bus_read_o),
  .bus_write_i  (bus_write_o)
);

// File: dv/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

  localparam int CLOCK_HALF   = 20;
  localparam int RESET_CYCLES = 3;
  localparam int STEP_LIMIT   = 1000;
  // Four bytes per instruction at most, two cycles per byte
  localparam int STEP_CYCLES  = 8;
  localparam int STALL_FACTOR = 8;

  logic        clock_i;
  logic        reset_i;
  logic [7:0]  data_i;
  logic        data_valid_i;
  logic [15:0] address_o;
  logic [7:0]  data_o;
  logic        bus_read_o;
  logic        bus_write_o;

  logic [7:0]  image [0:65535];
  logic [7:0]  mem [0:65535];
  logic [7:0]  model_mem [0:65535];
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  logic [15:0] halt_addr;
  logic [15:0] load_ptr;
  integer      seed = 32'hf7823d3c;
  logic        stall_enable = 1'b0;
  int          write_index;
  int          ref_steps;
  int          watchdog_cycles = 0;

  cpu_top dut0 (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .data_i       (data_i),
    .data_valid_i (data_valid_i),
    .address_o    (address_o),
    .data_o       (data_o),
    .bus_read_o   (bus_read_o),
    .bus_write_o  (bus_write_o)
  );

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s actual %h expected %h",
                         $time, name, actual, expected));
    end
  endtask

  function automatic logic [7:0] fill_byte(input logic [15:0] addr);
    return addr[15:8] ^ (addr[7:0] * 8'h1D) ^ 8'h5C;
  endfunction

  // One instruction of one to three bytes at load_ptr
  task automatic put(input int count, input logic [7:0] op, input logic [15:0] arg);
    image[load_ptr] = op;
    if (count > 1) begin
      image[load_ptr + 16'd1] = arg[7:0];
    end
    if (count > 2) begin
      image[load_ptr + 16'd2] = arg[15:8];
    end
    load_ptr = load_ptr + 16'(count);
  endtask

  task automatic build_image();
    for (int i = 0; i < 65536; i++) begin
      image[16'(i)] = fill_byte(16'(i));
    end
    image[16'hFFFC] = 8'h00;
    image[16'hFFFD] = 8'h02;
    load_ptr = 16'h0200;
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h005A);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0010);
    put(3, cpu_isa_pkg::OP_JMP_ABS, 16'h8000);
    load_ptr = 16'h8000;
    put(2, cpu_isa_pkg::OP_LDX_IMM, 16'h0081);
    put(1, cpu_isa_pkg::OP_TXA, 16'h0000);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0011);
    put(2, cpu_isa_pkg::OP_LDY_ZP, 16'h0020);
    put(1, cpu_isa_pkg::OP_TYA, 16'h0000);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0012);
    // Stack pointer round trip
    put(2, cpu_isa_pkg::OP_LDA_ZP, 16'h0010);
    put(1, cpu_isa_pkg::OP_TAX, 16'h0000);
    put(1, cpu_isa_pkg::OP_TXS, 16'h0000);
    put(2, cpu_isa_pkg::OP_LDX_ZP, 16'h0021);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h0000);
    put(1, cpu_isa_pkg::OP_TSX, 16'h0000);
    put(1, cpu_isa_pkg::OP_TXA, 16'h0000);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0013);
    put(2, cpu_isa_pkg::OP_LDY_IMM, 16'h0000);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h003C);
    put(1, cpu_isa_pkg::OP_TAY, 16'h0000);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h0000);
    put(1, cpu_isa_pkg::OP_TYA, 16'h0000);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0014);
    put(1, cpu_isa_pkg::OP_SEC, 16'h0000);
    // Carry out of the first add feeds the second
    put(1, cpu_isa_pkg::OP_CLC, 16'h0000);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h00F0);
    put(2, cpu_isa_pkg::OP_ADC_IMM, 16'h0020);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0015);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h0000);
    put(2, cpu_isa_pkg::OP_ADC_IMM, 16'h0000);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0016);
    put(1, cpu_isa_pkg::OP_SEC, 16'h0000);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h0010);
    put(2, cpu_isa_pkg::OP_SBC_IMM, 16'h0020);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0017);
    put(1, cpu_isa_pkg::OP_NOP, 16'h0000);
    put(2, cpu_isa_pkg::OP_LDA_IMM, 16'h0005);
    put(2, cpu_isa_pkg::OP_SBC_IMM, 16'h0001);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0018);
    put(3, cpu_isa_pkg::OP_LDA_ABS, 16'hF123);
    put(2, cpu_isa_pkg::OP_STA_ZP, 16'h0019);
    put(3, cpu_isa_pkg::OP_JMP_ABS, load_ptr);
  endtask

  // Instruction-level model, returns 1 once it reaches a jump to itself
  function automatic logic run_reference();
    logic [15:0] pc;
    logic [7:0]  op;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  s;
    logic        c;
    logic [8:0]  sum;
    logic        done;
    for (int i = 0; i < 65536; i++) begin
      model_mem[16'(i)] = image[16'(i)];
    end
    pc = {model_mem[16'hFFFD], model_mem[16'hFFFC]};
    a = 8'h00;
    x = 8'h00;
    y = 8'h00;
    s = 8'h00;
    c = 1'b0;
    done = 1'b0;
    ref_steps = 0;
    while (!done && ref_steps < STEP_LIMIT) begin
      op = model_mem[pc];
      b1 = model_mem[pc + 16'd1];
      b2 = model_mem[pc + 16'd2];
      ref_steps++;
      case (op)
        cpu_isa_pkg::OP_SEC, cpu_isa_pkg::OP_CLC: begin
          c = (op == cpu_isa_pkg::OP_SEC);
          pc = pc + 16'd1;
        end
        cpu_isa_pkg::OP_LDA_IMM: a = b1;
        cpu_isa_pkg::OP_LDX_IMM: x = b1;
        cpu_isa_pkg::OP_LDY_IMM: y = b1;
        cpu_isa_pkg::OP_LDA_ZP:  a = model_mem[{8'h00, b1}];
        cpu_isa_pkg::OP_LDX_ZP:  x = model_mem[{8'h00, b1}];
        cpu_isa_pkg::OP_LDY_ZP:  y = model_mem[{8'h00, b1}];
        cpu_isa_pkg::OP_STA_ZP: begin
          model_mem[{8'h00, b1}] = a;
          exp_addr.push_back({8'h00, b1});
          exp_data.push_back(a);
        end
        cpu_isa_pkg::OP_ADC_IMM, cpu_isa_pkg::OP_SBC_IMM: begin
          if (op == cpu_isa_pkg::OP_SBC_IMM) begin
            sum = {1'b0, a} + {1'b0, ~b1} + {8'h00, c};
          end else begin
            sum = {1'b0, a} + {1'b0, b1} + {8'h00, c};
          end
          a = sum[7:0];
          c = sum[8];
        end
        cpu_isa_pkg::OP_TAX: x = a;
        cpu_isa_pkg::OP_TAY: y = a;
        cpu_isa_pkg::OP_TXA: a = x;
        cpu_isa_pkg::OP_TYA: a = y;
        cpu_isa_pkg::OP_TXS: s = x;
        cpu_isa_pkg::OP_TSX: x = s;
        cpu_isa_pkg::OP_LDA_ABS: a = model_mem[{b2, b1}];
        cpu_isa_pkg::OP_JMP_ABS: begin
          if ({b2, b1} == pc) begin
            halt_addr = pc;
            done = 1'b1;
          end else begin
            pc = {b2, b1};
          end
        end
        default: pc = pc + 16'd1;
      endcase
      // PC step by instruction length
      case (op)
        cpu_isa_pkg::OP_LDA_IMM, cpu_isa_pkg::OP_LDX_IMM, cpu_isa_pkg::OP_LDY_IMM,
        cpu_isa_pkg::OP_LDA_ZP, cpu_isa_pkg::OP_LDX_ZP, cpu_isa_pkg::OP_LDY_ZP,
        cpu_isa_pkg::OP_STA_ZP, cpu_isa_pkg::OP_ADC_IMM, cpu_isa_pkg::OP_SBC_IMM:
          pc = pc + 16'd2;
        cpu_isa_pkg::OP_TAX, cpu_isa_pkg::OP_TAY, cpu_isa_pkg::OP_TXA,
        cpu_isa_pkg::OP_TYA, cpu_isa_pkg::OP_TXS, cpu_isa_pkg::OP_TSX:
          pc = pc + 16'd1;
        cpu_isa_pkg::OP_LDA_ABS: pc = pc + 16'd3;
        default: pc = pc;
      endcase
    end
    return done;
  endfunction

  function automatic logic stall_now();
    return stall_enable && (($random(seed) & 7) < 3);
  endfunction

  initial begin
    clock_i = 1'b0;
    forever #CLOCK_HALF clock_i = ~clock_i;
  end

  // Memory model, one answer per read request
  initial begin
    data_i       = 8'h00;
    data_valid_i = 1'b0;
    forever begin
      @(posedge clock_i);
      if (reset_i) begin
        data_valid_i <= 1'b0;
        for (int i = 0; i < 65536; i++) begin
          mem[16'(i)] = image[16'(i)];
        end
      end else begin
        if (bus_write_o) begin
          mem[address_o] = data_o;
        end
        if (bus_read_o && !data_valid_i && !stall_now()) begin
          data_i       <= mem[address_o];
          data_valid_i <= 1'b1;
        end else begin
          data_valid_i <= 1'b0;
        end
      end
    end
  end

  always @(posedge clock_i) begin
    if (reset_i) begin
      write_index <= 0;
    end else if (bus_write_o) begin
      if (write_index >= exp_addr.size()) begin
        stop_run("A bus write appeared after all expected writes were seen");
      end else begin
        check_value("address_o", address_o, exp_addr[write_index]);
        check_value("data_o", {8'h00, data_o}, {8'h00, exp_data[write_index]});
        write_index <= write_index + 1;
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clock_i);
    stop_run($sformatf("Timeout after %0d cycles before the program reached its halt loop",
                       watchdog_cycles));
  end

  task automatic run_program(input logic stalls);
    logic halted;
    stall_enable = stalls;
    reset_i <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_i);
    reset_i <= 1'b0;
    halted = 1'b0;
    while (!halted) begin
      @(posedge clock_i);
      halted = bus_read_o && data_valid_i && (address_o == halt_addr);
    end
    check_value("write_index", 16'(write_index), 16'(exp_addr.size()));
  endtask

  initial begin
    build_image();
    if (!run_reference()) begin
      stop_run("Reference model did not reach a halt loop");
    end
    watchdog_cycles = 2 * (ref_steps * STEP_CYCLES + 2 * RESET_CYCLES) * STALL_FACTOR;
    run_program(1'b0);
    run_program(1'b1);
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: verilog.f
common/cpu_isa_pkg.sv
common/cpu_ctrl_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/address_unit.sv
sequencer/cpu_sequencer.sv
logic/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -o cpu_sim \
  -f verilog.f || { echo "Build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qx "Testbench passed" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }
